/* files.f */
common/ppu_pkg.sv
background/tile_decode.sv
background/line_fetch.sv
verilog/palette_fetch.sv
verilog/pixel_out.sv
verilog/ppu_background.sv
test/ppu_props.sv
test/ppu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= ppu_tb
BUILD_DIR ?= obj_dir
FILE_LIST ?= files.f
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* test/ppu_tb.sv */
`timescale 1ns/1ps

module ppu_tb import ppu_pkg::*; ();

    localparam int ACTIVE_PIXELS = TILES_PER_LINE * 32; // 32 columns per tile
    localparam int VBLANK_CYCLES = 12;
    localparam int HSYNC_CYCLES = 45;

    logic clk;
    logic reset;
    vga_timing_t timing;
    logic [WORD_W-1:0] read_data_tile_buffer;
    logic [WORD_W-1:0] read_data_tile_graphics;
    color_t read_data_color_palettes;
    logic [TB_ADDR_W-1:0] addr_tile_buffer;
    logic [TG_ADDR_W-1:0] addr_tile_graphics;
    logic [PAL_ADDR_W-1:0] addr_color_palettes;
    color_t pixel_color;

    // Memory contents
    logic [WORD_W-1:0] tile_buffer_mem [0:(1 << TB_ADDR_W) - 1];
    logic [WORD_W-1:0] tile_graphics_mem [0:(1 << TG_ADDR_W) - 1];
    color_t palette_mem [0:PALETTE_ENTRIES-1];

    integer seed = 32'h6b54_2527;
    int check_errors = 0;  // Address and reset checks
    int pixel_errors = 0;  // Written only by the comparing process
    int pixel_checks = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int errors_at_start;
    string test_name;

    logic compare_en;
    logic prev_valid = 1'b0;
    logic [HCOUNT_W-1:0] prev_hcount;
    logic [VCOUNT_W-1:0] prev_vcount;

    ppu_background ppu_background_inst (
        .clk                      (clk),
        .reset                    (reset),
        .timing                   (timing),
        .read_data_tile_buffer    (read_data_tile_buffer),
        .read_data_tile_graphics  (read_data_tile_graphics),
        .read_data_color_palettes (read_data_color_palettes),
        .addr_tile_buffer         (addr_tile_buffer),
        .addr_tile_graphics       (addr_tile_graphics),
        .addr_color_palettes      (addr_color_palettes),
        .pixel_color              (pixel_color)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Registered one-cycle read on all three memories
    always @(posedge clk) begin : memory_models
        logic [TB_ADDR_W-1:0] tb_addr;
        logic [TG_ADDR_W-1:0] tg_addr;
        logic [PAL_ADDR_W-1:0] pal_addr;
        tb_addr = addr_tile_buffer;
        tg_addr = addr_tile_graphics;
        pal_addr = addr_color_palettes;
        #1;
        read_data_tile_buffer = tile_buffer_mem[tb_addr];
        read_data_tile_graphics = tile_graphics_mem[tg_addr];
        read_data_color_palettes = palette_mem[pal_addr];
    end

    // Byte of the tile buffer for one tile column of the line at v
    function automatic logic [7:0] tile_entry_of(input logic [VCOUNT_W-1:0] v,
                                                 input int column);
        logic [WORD_W-1:0] word;
        word = tile_buffer_mem[v[9:5] * WORDS_PER_ROW + column / TILES_PER_WORD];
        return word[8 * (column % TILES_PER_WORD) +: 8];
    endfunction

    function automatic color_t ref_color(input logic [HCOUNT_W-1:0] h,
                                         input logic [VCOUNT_W-1:0] v);
        logic [7:0] entry_byte;
        logic [WORD_W-1:0] gfx;
        logic [1:0] pix;
        entry_byte = tile_entry_of(v, int'(h[10:5]));
        gfx = tile_graphics_mem[entry_byte[6:0] * TILE_LINES + v[4:1]];
        pix = gfx[2 * h[4:1] +: 2];   // Source pixel spans two columns
        return palette_mem[{entry_byte[7], pix}];
    endfunction

    // Pixel of the previous cycle shows up one cycle later
    always @(negedge clk) begin : compare_pixels
        color_t expected;
        if (prev_valid) begin
            expected = ref_color(prev_hcount, prev_vcount);
            pixel_checks++;
            assert (pixel_color === expected) else begin
                $display("mismatch at %0t ns: pixel at h %0d v %0d is %06h, expected %06h",
                         $time, prev_hcount, prev_vcount, pixel_color, expected);
                pixel_errors++;
            end
        end
        prev_valid = compare_en && !timing.vblank && !timing.hsync;
        prev_hcount = timing.hcount;
        prev_vcount = timing.vcount;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            $display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
            check_errors++;
        end
    endtask

    // One clock cycle of timing, returns mid cycle
    task automatic step(input logic [HCOUNT_W-1:0] h, input logic [VCOUNT_W-1:0] v,
                        input logic vb, input logic hs, input logic chk);
        @(posedge clk);
        #1;
        timing.hcount = h;
        timing.vcount = v;
        timing.vblank = vb;
        timing.hsync = hs;
        compare_en = chk;
        @(negedge clk);
    endtask

    task automatic run_vblank(input logic [VCOUNT_W-1:0] v);
        for (int k = 0; k < VBLANK_CYCLES; k++) begin
            step(11'd0, v, 1'b1, 1'b0, 1'b0);
            check_value("addr_color_palettes", addr_color_palettes,
                        (k < PALETTE_ENTRIES) ? k : 0);
        end
        step(11'd0, v, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic run_hsync(input logic [VCOUNT_W-1:0] v, input int cycles, input bit check);
        logic [7:0] entry_byte;
        int expected_tb;
        int expected_tg;
        for (int p = 0; p < cycles; p++) begin
            step(11'd0, v, 1'b0, 1'b1, 1'b0);
            if (check) begin
                expected_tb = (p < TILES_PER_LINE) ?
                    v[9:5] * WORDS_PER_ROW + p / TILES_PER_WORD : 0;
                expected_tg = 0;
                if (p >= 1 && p <= TILES_PER_LINE) begin
                    entry_byte = tile_entry_of(v, p - 1);  // Entry read one cycle back
                    expected_tg = entry_byte[6:0] * TILE_LINES + v[4:1];
                end
                check_value("addr_tile_buffer", addr_tile_buffer, expected_tb);
                check_value("addr_tile_graphics", addr_tile_graphics, expected_tg);
            end
        end
        step(11'd0, v, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic check_line(input logic [VCOUNT_W-1:0] v);
        for (int h = 0; h < ACTIVE_PIXELS; h++)
            step(HCOUNT_W'(h), v, 1'b0, 1'b0, 1'b1);
        // Last pixel is compared during the next cycle
        step(11'd0, v, 1'b0, 1'b1, 1'b0);
        step(11'd0, v, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = check_errors + pixel_errors;
    endtask

    task automatic end_test();
        int found;
        found = check_errors + pixel_errors - errors_at_start;
        if (found == 0) begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, found);
        end
    endtask

    initial begin : main
        logic [VCOUNT_W-1:0] v;
        logic [VCOUNT_W-1:0] v_cut;
        reset = 1'b1;
        timing = '0;
        compare_en = 1'b0;
        read_data_tile_buffer = '0;
        read_data_tile_graphics = '0;
        read_data_color_palettes = '0;

        for (int i = 0; i < (1 << TB_ADDR_W); i++)
            tile_buffer_mem[i] = $random(seed);
        for (int i = 0; i < (1 << TG_ADDR_W); i++)
            tile_graphics_mem[i] = $random(seed);
        for (int i = 0; i < PALETTE_ENTRIES; i++)
            palette_mem[i] = color_t'($random(seed));

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test("reset");
        @(negedge clk);
        check_value("pixel_color", pixel_color, 0);
        check_value("addr_tile_buffer", addr_tile_buffer, 0);
        check_value("addr_tile_graphics", addr_tile_graphics, 0);
        check_value("addr_color_palettes", addr_color_palettes, 0);
        end_test();

        begin_test("palette fetch");
        run_vblank(10'd0);
        end_test();

        begin_test("line fetch addresses");
        v = VCOUNT_W'($random(seed));
        run_hsync(v, HSYNC_CYCLES, 1'b1);
        end_test();

        begin_test("active lines");
        run_vblank(10'd0);
        for (int n = 0; n < 3; n++) begin
            v = VCOUNT_W'($random(seed));
            run_hsync(v, HSYNC_CYCLES, 1'b0);
            check_line(v);
        end
        end_test();

        begin_test("interrupted hsync");
        v_cut = VCOUNT_W'($random(seed));
        v = VCOUNT_W'($random(seed));
        run_hsync(v_cut, 10, 1'b0);  // Leaves the first slots from another line
        run_hsync(v, HSYNC_CYCLES, 1'b0);
        check_line(v);
        end_test();

        $display("tests: %0d passed, %0d failed, %0d pixel checks, %0d errors",
                 tests_passed, tests_failed, pixel_checks, check_errors + pixel_errors);
        if (tests_failed == 0 && check_errors + pixel_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* test/ppu_props.sv */
`timescale 1ns/1ps

module ppu_props import ppu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic vblank,
    input logic hsync,
    input logic [5:0] fetch_count,
    input logic [3:0] pal_count,
    input logic [PAL_ADDR_W-1:0] pal_addr,
    input logic [TB_ADDR_W-1:0] tb_addr,
    input logic [TG_ADDR_W-1:0] tg_addr
);

    // Address follows the vblank counter over the eight colors, then rests at 0
    palette_addr_seq: assert property (@(posedge clk) disable iff (reset)
        vblank |-> pal_addr == ((pal_count < PALETTE_ENTRIES) ? PAL_ADDR_W'(pal_count) : '0))
        else $error("palette address %0d at vblank cycle %0d", pal_addr, pal_count);

    // Counter holds at the end, nothing left to read while hsync lasts
    fetch_end_idle: assert property (@(posedge clk) disable iff (reset)
        (hsync && !vblank && $past(hsync && !vblank && fetch_count == TILES_PER_LINE + 2))
        |-> (fetch_count == TILES_PER_LINE + 2 && tb_addr == '0))
        else $error("tile-buffer address %0h after the line fetch ended", tb_addr);

    graphics_idle: assert property (@(posedge clk) disable iff (reset)
        !hsync |=> tg_addr == '0)
        else $error("graphics address %0h one cycle after hsync was low", tg_addr);

endmodule

// Palette side, line fetch signals held idle
bind palette_fetch ppu_props palette_props_inst (
    .clk         (clk),
    .reset       (reset),
    .vblank      (vblank),
    .hsync       (1'b0),
    .fetch_count (6'd0),
    .pal_count   (count),
    .pal_addr    (addr),
    .tb_addr     (9'd0),
    .tg_addr     (11'd0)
);

bind line_fetch ppu_props line_props_inst (
    .clk         (clk),
    .reset       (reset),
    .vblank      (vblank),
    .hsync       (hsync),
    .fetch_count (count),
    .pal_count   (4'd0),
    .pal_addr    (3'd0),
    .tb_addr     (addr_tile_buffer),
    .tg_addr     (addr_tile_graphics)
);

/* verilog/ppu_background.sv */
`timescale 1ns/1ps

module ppu_background import ppu_pkg::*; (
    input logic clk,
    input logic reset,
    input vga_timing_t timing,
    input logic [WORD_W-1:0] read_data_tile_buffer,
    input logic [WORD_W-1:0] read_data_tile_graphics,
    input color_t read_data_color_palettes,
    output logic [TB_ADDR_W-1:0] addr_tile_buffer,
    output logic [TG_ADDR_W-1:0] addr_tile_graphics,
    output logic [PAL_ADDR_W-1:0] addr_color_palettes,
    output color_t pixel_color
);

    color_t [PALETTE_ENTRIES-1:0] palette;
    line_slot_t [TILES_PER_LINE-1:0] line;

    // Fetcher to decoder
    logic [WORD_W-1:0] tile_word;
    logic [1:0] entry_index;
    logic [3:0] tile_line;
    tile_entry_t entry;
    logic [TG_ADDR_W-1:0] graphics_addr;

    palette_fetch palette_fetch_inst (
        .clk       (clk),
        .reset     (reset),
        .vblank    (timing.vblank),
        .read_data (read_data_color_palettes),
        .addr      (addr_color_palettes),
        .palette   (palette)
    );

    line_fetch line_fetch_inst (
        .clk                     (clk),
        .reset                   (reset),
        .vblank                  (timing.vblank),
        .hsync                   (timing.hsync),
        .vcount                  (timing.vcount),
        .read_data_tile_buffer   (read_data_tile_buffer),
        .read_data_tile_graphics (read_data_tile_graphics),
        .entry                   (entry),
        .graphics_addr           (graphics_addr),
        .tile_word               (tile_word),
        .entry_index             (entry_index),
        .tile_line               (tile_line),
        .addr_tile_buffer        (addr_tile_buffer),
        .addr_tile_graphics      (addr_tile_graphics),
        .line                    (line)
    );

    tile_decode tile_decode_inst (
        .tile_word     (tile_word),
        .entry_index   (entry_index),
        .tile_line     (tile_line),
        .entry         (entry),
        .graphics_addr (graphics_addr)
    );

    pixel_out pixel_out_inst (
        .clk         (clk),
        .reset       (reset),
        .timing      (timing),
        .line        (line),
        .palette     (palette),
        .pixel_color (pixel_color)
    );

endmodule

/* verilog/pixel_out.sv */
`timescale 1ns/1ps

module pixel_out import ppu_pkg::*; (
    input logic clk,
    input logic reset,
    input vga_timing_t timing,
    input line_slot_t [TILES_PER_LINE-1:0] line,
    input color_t [PALETTE_ENTRIES-1:0] palette,
    output color_t pixel_color
);

    line_slot_t cur_slot;
    logic [3:0] pixel_index;
    logic [1:0] pixel_value;
    logic [PAL_ADDR_W-1:0] color_index;

    // Every source pixel spans two columns, every tile 32 columns
    assign cur_slot = line[timing.hcount[10:5]];
    assign pixel_index = timing.hcount[4:1];
    assign pixel_value = cur_slot.graphics[{pixel_index, 1'b0} +: 2];

    // Palette bit picks the upper four colors
    assign color_index = {cur_slot.palette, pixel_value};

    always_ff @(posedge clk) begin
        if (reset)
            pixel_color <= '0;
        else if (!timing.vblank && !timing.hsync)
            pixel_color <= palette[color_index];
    end

endmodule

/* verilog/palette_fetch.sv */
`timescale 1ns/1ps

module palette_fetch import ppu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic vblank,
    input color_t read_data,
    output logic [PAL_ADDR_W-1:0] addr,
    output color_t [PALETTE_ENTRIES-1:0] palette
);

    logic [3:0] count; // Vblank cycle, stops at PALETTE_ENTRIES + 1
    logic [3:0] count_next;

    assign count_next = count + 4'd1;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            addr <= '0;
            palette <= '0;
        end else if (vblank) begin
            if (count < PALETTE_ENTRIES + 1)
                count <= count_next;

            // Load the address for the coming cycle, so cycle k shows address k.
            // The idle value 0 already covers cycle 0.
            if (count_next < PALETTE_ENTRIES)
                addr <= PAL_ADDR_W'(count_next);
            else
                addr <= '0;

            // Data for cycle k-1's address
            if (count != 0 && count <= PALETTE_ENTRIES)
                palette[PAL_ADDR_W'(count - 4'd1)] <= read_data;
        end else begin
            count <= '0;
            addr <= '0;
        end
    end

endmodule

/* background/line_fetch.sv */
`timescale 1ns/1ps

module line_fetch import ppu_pkg::*; (
    input logic clk,
    input logic reset,
    input logic vblank,
    input logic hsync,
    input logic [VCOUNT_W-1:0] vcount,
    input logic [WORD_W-1:0] read_data_tile_buffer,
    input logic [WORD_W-1:0] read_data_tile_graphics,

    // Decoder side
    input tile_entry_t entry,
    input logic [TG_ADDR_W-1:0] graphics_addr,
    output logic [WORD_W-1:0] tile_word,
    output logic [1:0] entry_index,
    output logic [3:0] tile_line,

    output logic [TB_ADDR_W-1:0] addr_tile_buffer,
    output logic [TG_ADDR_W-1:0] addr_tile_graphics,
    output line_slot_t [TILES_PER_LINE-1:0] line
);

    logic [5:0] count;    // Fetch position, stops at TILES_PER_LINE + 2
    logic [5:0] slot_pal; // Slot whose palette bit and graphics address are handled now
    logic [5:0] slot_gfx; // Slot whose graphics word arrives now
    logic fetching;
    logic tb_stage;
    logic tg_stage;
    logic store_stage;
    logic [4:0] tile_row;

    // Vblank wins over hsync
    assign fetching = hsync && !vblank;

    assign slot_pal = count - 6'd1;
    assign slot_gfx = count - 6'd2;
    assign tile_row = vcount[9:5];

    // Three tiles in flight: word read, graphics read, graphics store
    assign tb_stage = fetching && (count < TILES_PER_LINE);
    assign tg_stage = fetching && (count >= 1) && (count <= TILES_PER_LINE);
    assign store_stage = fetching && (count >= 2) && (count <= TILES_PER_LINE + 1);

    // Tile-buffer word that came back for the address of the previous cycle
    assign tile_word = read_data_tile_buffer;
    assign entry_index = slot_pal[1:0];
    assign tile_line = vcount[4:1];

    // Addresses follow the counter within the same cycle
    assign addr_tile_buffer = tb_stage ?
        TB_ADDR_W'(tile_row * WORDS_PER_ROW + count / TILES_PER_WORD) : '0;
    assign addr_tile_graphics = tg_stage ? graphics_addr : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
            line <= '0;
        end else if (fetching) begin
            if (count < TILES_PER_LINE + 2)
                count <= count + 6'd1;

            if (tg_stage)
                line[slot_pal].palette <= entry.palette;

            if (store_stage)
                line[slot_gfx].graphics <= read_data_tile_graphics; // Word for slot two back
        end else begin
            count <= '0; // Slots keep whatever was written so far
        end
    end

endmodule

/* background/tile_decode.sv */
`timescale 1ns/1ps

module tile_decode import ppu_pkg::*; (
    input logic [WORD_W-1:0] tile_word,
    input logic [1:0] entry_index,       // Which byte of the word
    input logic [3:0] tile_line,         // Source line inside the tile
    output tile_entry_t entry,
    output logic [TG_ADDR_W-1:0] graphics_addr
);

    // Tile-buffer word viewed as its four entries, entry 0 in the low byte
    tile_entry_t [TILES_PER_WORD-1:0] entries;

    assign entries = tile_word;
    assign entry = entries[entry_index];

    // Each tile owns TILE_LINES consecutive graphics words
    assign graphics_addr = TG_ADDR_W'(entry.tile_id * TILE_LINES + tile_line);

endmodule

/* common/ppu_pkg.sv */
package ppu_pkg;

    // Screen and counter widths
    localparam int HCOUNT_W = 11;
    localparam int VCOUNT_W = 10;

    // Tile layout
    localparam int TILES_PER_LINE = 40;
    localparam int TILES_PER_WORD = 4; // Byte sized entries in one tile-buffer word
    localparam int WORDS_PER_ROW = 10;
    localparam int TILE_LINES = 16;    // Source lines per tile, also graphics stride
    localparam int PALETTE_ENTRIES = 8;

    // Memory widths
    localparam int WORD_W = 32;
    localparam int TB_ADDR_W = 9;
    localparam int TG_ADDR_W = 11;
    localparam int PAL_ADDR_W = 3;

    typedef logic [23:0] color_t;

    // One tile-buffer byte
    typedef struct packed {
        logic palette;       // Selects upper or lower half of the palette
        logic [6:0] tile_id;
    } tile_entry_t;

    // One tile's worth of the current line
    typedef struct packed {
        logic [WORD_W-1:0] graphics; // 16 pixels, two bits each
        logic palette;
    } line_slot_t;

    typedef struct packed {
        logic [HCOUNT_W-1:0] hcount;
        logic [VCOUNT_W-1:0] vcount;
        logic vblank;
        logic hsync;
    } vga_timing_t;

endpackage
